// ==== compile.f ====
hw/mem_bus_pkg.sv
hw/fetch_pkg.sv
hw/imem_bus_if.sv
hw/icache.sv
hw/fetch_sequencer.sv
hw/fetch_unit.sv
dv/tb_fetch_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_fetch_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_fetch_unit;

  localparam logic [31:0] RESET_PC = 32'h0000_0010;
  localparam int CLOCK_PERIOD  = 10;
  localparam int MAX_LATENCY   = 6;
  localparam int MARGIN        = 8;
  localparam int TOTAL_FETCHES = 1 + 60 + 12 + 36 + 150; // sum over all tests

  logic clock, reset, redirect, fetch_valid, fetch_taken;
  logic [31:0] redirect_pc, mem_addr, fetch_pc, fetch_instr, expected_pc;
  logic [63:0] mem_data;
  mem_bus_pkg::bus_command_e mem_command;
  mem_bus_pkg::mem_tag_t     mem_response, mem_tag;

  logic [31:0] mem_words [16384]; // 64 KB of instruction memory
  logic [31:0] lfsr_state = 32'h6f28c75b;
  int fetch_count = 0;
  int check_count = 0;
  int error_count = 0;
  int test_fetches = 0;
  int test_errors = 0;

  fetch_unit #(
    .RESET_PC     (RESET_PC),
    .ICACHE_LINES (128)
  ) uut (
    .i_clock        (clock),
    .i_reset        (reset),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .i_mem_response (mem_response),
    .i_mem_data     (mem_data),
    .i_mem_tag      (mem_tag),
    .i_redirect     (redirect),
    .i_redirect_pc  (redirect_pc),
    .o_fetch_valid  (fetch_valid),
    .o_fetch_pc     (fetch_pc),
    .o_fetch_instr  (fetch_instr),
    .o_fetch_taken  (fetch_taken)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // fibonacci lfsr with taps 32 22 2 1 that steps once per bit
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int n = 0; n < count; n++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [31:0] jal_word(input logic [31:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [31:0] branch_word(input logic [31:0] offset);
    return {offset[12], offset[10:5], 5'd2, 5'd1, 3'b001, offset[4:1], offset[11], 7'b1100011};
  endfunction

  function automatic void plant(input logic [31:0] addr, input logic [31:0] word);
    mem_words[addr[15:2]] = word;
  endfunction

  function automatic logic [63:0] line_words(input logic [12:0] line);
    return {mem_words[{line, 1'b1}], mem_words[{line, 1'b0}]};
  endfunction

  // looks up the expected word at pc and returns the predicted next pc
  function automatic logic [31:0] predict(input logic [31:0] pc, output logic [31:0] instr,
                                          output logic taken);
    logic [31:0] w, j_off, b_off;
    w     = mem_words[pc[15:2]];
    j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    instr = w;
    taken = 1'b1;
    if (w[6:0] == 7'b1101111) begin
      return pc + j_off;
    end
    if (w[6:0] == 7'b1100011 && b_off[31]) begin
      return pc + b_off; // only backward branches are predicted taken
    end
    taken = 1'b0;
    return pc + 32'd4;
  endfunction

  task automatic load_memory();
    logic [31:0] word;
    for (int i = 0; i < 16384; i++) begin
      word = lfsr_bits(32);
      // filler never jumps so control flow only goes where code is planted
      if (word[6:0] == 7'b1101111 || word[6:0] == 7'b1100011) begin
        word[6:0] = 7'b0010011;
      end
      mem_words[14'(i)] = word;
    end
    plant(32'h0000_0020, branch_word(32'h0000_0040)); // forward branch that falls through
    plant(32'h0000_0040, jal_word(32'h0000_01c0));
    plant(32'h0000_0220, branch_word(32'hffff_ffe0)); // loop back to 0x200
    plant(32'h0000_101c, jal_word(32'hffff_f1e4));
    plant(32'h0000_0804, branch_word(32'hffff_fffc));
    plant(32'h0000_0c04, branch_word(32'hffff_fffc)); // same cache line as 0x804
    plant(32'h0000_2200, jal_word(32'hffff_fe00));
  endtask

  task automatic compare_pc(input fetch_pkg::fetch_packet_t got, exp);
    check_count++;
    if (got.pc !== exp.pc) begin
      error_count++;
      $display("Error: o_fetch_pc got %h expected %h", got.pc, exp.pc);
    end
  endtask

  task automatic compare_instr(input fetch_pkg::fetch_packet_t got, exp);
    check_count++;
    if (got.instr !== exp.instr) begin
      error_count++;
      $display("Error: o_fetch_instr got %h expected %h at pc %h", got.instr, exp.instr, exp.pc);
    end
  endtask

  task automatic compare_taken(input fetch_pkg::fetch_packet_t got, exp);
    check_count++;
    if (got.taken !== exp.taken) begin
      error_count++;
      $display("Error: o_fetch_taken got %h expected %h at pc %h", got.taken, exp.taken, exp.pc);
    end
  endtask

  // tagged memory that refuses about half the requests and answers after 1 to 6 cycles
  initial begin : memory_model
    logic        busy [16];
    int          due [16];
    logic [12:0] line_of [16];
    logic [4:0]  t;
    logic        in_reset;
    int          cycle;
    mem_bus_pkg::mem_tag_t grant, ret;
    mem_response = '0;
    mem_tag      = '0;
    mem_data     = '0;
    cycle        = 0;
    for (t = 5'd0; t < 5'd16; t++) begin
      busy[t[3:0]] = 1'b0;
    end
    forever begin
      @(posedge clock);
      in_reset = reset;
      @(negedge clock);
      cycle++;
      grant = '0;
      ret   = '0;
      if (!in_reset && mem_command == mem_bus_pkg::BUS_LOAD && lfsr_bits(1) != 0) begin
        for (t = 5'd15; t >= 5'd1; t--) begin
          if (!busy[t[3:0]]) begin
            grant = t[3:0];
          end
        end
      end
      for (t = 5'd1; t < 5'd16; t++) begin
        if (busy[t[3:0]] && due[t[3:0]] <= cycle && ret == '0) begin
          ret = t[3:0]; // one response per cycle so late ones wait
        end
      end
      if (ret != '0) begin
        busy[ret] = 1'b0;
      end
      if (grant != '0) begin
        busy[grant]    = 1'b1;
        due[grant]     = cycle + 1 + int'(lfsr_bits(3)) % MAX_LATENCY;
        line_of[grant] = mem_addr[15:3];
      end
      mem_response = grant;
      mem_tag      = ret;
      mem_data     = ret != '0 ? line_words(line_of[ret]) : '0;
    end
  end

  initial begin : compare
    fetch_pkg::fetch_packet_t got, exp;
    logic [31:0] next_pc, exp_instr;
    logic        exp_taken, in_reset;
    expected_pc = RESET_PC;
    forever begin
      @(posedge clock);
      in_reset = reset;
      if (redirect === 1'b1) begin
        expected_pc = redirect_pc;
      end
      @(negedge clock);
      if (in_reset && fetch_valid !== 1'b0) begin
        error_count++;
        $display("the fetch strobe was not low while reset was held");
      end else if (fetch_valid === 1'b1) begin
        got     = '{pc: fetch_pc, instr: fetch_instr, taken: fetch_taken};
        next_pc = predict(expected_pc, exp_instr, exp_taken);
        exp     = '{pc: expected_pc, instr: exp_instr, taken: exp_taken};
        compare_pc(got, exp);
        compare_instr(got, exp);
        compare_taken(got, exp);
        expected_pc = next_pc;
        fetch_count++;
      end
    end
  end

  initial begin : watchdog
    #(TOTAL_FETCHES * MAX_LATENCY * MARGIN * CLOCK_PERIOD);
    $display("the fetch stream stalled, only %0d fetches arrived", fetch_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic redirect_to(input logic [31:0] target);
    @(negedge clock);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clock);
    redirect    = 1'b0;
  endtask

  task automatic wait_fetches(input int count);
    int target;
    target = fetch_count + count;
    while (fetch_count < target) begin
      @(posedge clock);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-12s fetches %0d errors %0d", name, fetch_count - test_fetches,
             error_count - test_errors);
    test_fetches = fetch_count;
    test_errors  = error_count;
  endtask

  initial begin
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    load_memory();
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    wait_fetches(1);
    end_test("reset_start");
    wait_fetches(60);
    end_test("stream");
    redirect_to(32'h0000_1000);
    wait_fetches(12);
    end_test("redirect");
    for (int i = 0; i < 6; i++) begin
      redirect_to(32'h0000_0800);
      repeat (2) @(negedge clock); // leaves a fill for 0x800 in flight
      redirect_to(32'h0000_0c00);
      wait_fetches(3);
      redirect_to(32'h0000_0800);
      wait_fetches(3);
    end
    end_test("alias");
    redirect_to(32'h0000_2000);
    wait_fetches(150);
    end_test("straight_run");
    $display("fetches %0d checks %0d errors %0d", fetch_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [31:0] RESET_PC     = 32'h0,
  parameter int          ICACHE_LINES = 128
) (
  input  logic                      i_clock,
  input  logic                      i_reset,
  output mem_bus_pkg::bus_command_e o_mem_command,
  output logic [31:0]               o_mem_addr,
  input  mem_bus_pkg::mem_tag_t     i_mem_response,
  input  logic [63:0]               i_mem_data,
  input  mem_bus_pkg::mem_tag_t     i_mem_tag,
  input  logic                      i_redirect,
  input  logic [31:0]               i_redirect_pc,
  output logic                      o_fetch_valid,
  output logic [31:0]               o_fetch_pc,
  output logic [31:0]               o_fetch_instr,
  output logic                      o_fetch_taken
);

  imem_bus_if mem_bus ();

  logic [31:0] pc;
  logic [63:0] line_data;
  logic        hit;
  fetch_pkg::fetch_packet_t packet;

  // memory side of the bus goes straight out to the pins
  assign o_mem_command    = mem_bus.command;
  assign o_mem_addr       = mem_bus.addr;
  assign mem_bus.response = i_mem_response;
  assign mem_bus.data     = i_mem_data;
  assign mem_bus.tag      = i_mem_tag;

  icache #(
    .ICACHE_LINES (ICACHE_LINES)
  ) u_icache (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_lookup_addr (pc),
    .o_line_data   (line_data),
    .o_hit         (hit),
    .mem           (mem_bus)
  );

  fetch_sequencer #(
    .RESET_PC (RESET_PC)
  ) u_fetch_sequencer (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_line_data    (line_data),
    .i_hit          (hit),
    .i_redirect     (i_redirect),
    .i_redirect_pc  (i_redirect_pc),
    .o_pc           (pc),
    .o_fetch_valid  (o_fetch_valid),
    .o_fetch_packet (packet)
  );

  assign o_fetch_pc    = packet.pc;
  assign o_fetch_instr = packet.instr;
  assign o_fetch_taken = packet.taken;

endmodule

`default_nettype wire

// ==== hw/fetch_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_sequencer #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic [63:0]              i_line_data,
  input  logic                     i_hit,
  input  logic                     i_redirect,
  input  logic [31:0]              i_redirect_pc,
  output logic [31:0]              o_pc,
  output logic                     o_fetch_valid,
  output fetch_pkg::fetch_packet_t o_fetch_packet
);

  logic [31:0] pc, next_pc;
  logic [31:0] j_imm, b_imm;
  logic        is_jal, is_back_branch, taken;
  fetch_pkg::instr_word_u word;

  assign o_pc = pc;

  // each line holds two instructions, pc bit 2 picks one
  assign word = pc[2] ? i_line_data[63:32] : i_line_data[31:0];

  assign j_imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12, word.j.imm11,
                  word.j.imm10_1, 1'b0};
  assign b_imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11, word.b.imm10_5,
                  word.b.imm4_1, 1'b0};

  assign is_jal         = word.j.opcode == fetch_pkg::OPC_JAL;
  assign is_back_branch = word.b.opcode == fetch_pkg::OPC_BRANCH && word.b.imm12; // loops
  assign taken          = is_jal || is_back_branch;

  always_comb begin
    if (is_jal) begin
      next_pc = pc + j_imm;
    end else if (is_back_branch) begin
      next_pc = pc + b_imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      pc            <= RESET_PC;
      o_fetch_valid <= 1'b0;
    end else if (i_redirect) begin
      pc            <= i_redirect_pc; // a hit in the same cycle is on the old path
      o_fetch_valid <= 1'b0;
    end else begin
      o_fetch_valid <= i_hit;
      if (i_hit) begin
        pc <= next_pc;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_hit) begin
      o_fetch_packet.pc    <= pc;
      o_fetch_packet.instr <= word.raw;
      o_fetch_packet.taken <= taken;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`default_nettype none
`timescale 1ns/1ps

module icache #(
  parameter int ICACHE_LINES = 128
) (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic [31:0] i_lookup_addr,
  output logic [63:0] o_line_data,
  output logic        o_hit,
  imem_bus_if.cache   mem
);

  localparam int LINE_W = 13; // line number inside the 64 KB space
  localparam int IDX_W  = $clog2(ICACHE_LINES);

  mem_bus_pkg::icache_line_t   [ICACHE_LINES-1:0] lines, next_lines;
  mem_bus_pkg::mem_tag_entry_t [15:0]             tag_table, next_tag_table;
  mem_bus_pkg::mem_tag_entry_t                    fill_entry;

  logic [IDX_W-1:0] head, tail, next_head, next_tail;
  logic [IDX_W-1:0] idx, tail_next, ahead, req_idx, fill_idx;
  logic [LINE_W-1:0] cur_line, pf_line, req_line;
  logic [mem_bus_pkg::LINE_TAG_W-1:0] tag, req_tag;
  logic in_window, match, keep, window_full, prefetch, accepted;

  assign cur_line = i_lookup_addr[15:3];
  assign idx      = cur_line[IDX_W-1:0];
  assign tag      = mem_bus_pkg::LINE_TAG_W'(cur_line[LINE_W-1:IDX_W]);

  assign tail_next   = tail + 1'b1;
  assign in_window   = (idx - head) <= (tail - head); // circular distance from head
  assign window_full = tail_next == head;

  // a matching tag on an invalid line means a fill for it is still in flight
  assign match = lines[idx].tag == tag;
  assign keep  = in_window && match;

  assign o_hit       = lines[idx].valid && match;
  assign o_line_data = lines[idx].data;

  // the line after tail, counted from the lookup line so wrap carries into the tag
  assign ahead    = tail - idx;
  assign prefetch = keep && o_hit && !window_full;
  assign pf_line  = cur_line + LINE_W'(ahead) + LINE_W'(1);

  // anything short of a hit asks for the lookup line again
  assign req_line = prefetch ? pf_line : cur_line;
  assign req_idx  = req_line[IDX_W-1:0];
  assign req_tag  = mem_bus_pkg::LINE_TAG_W'(req_line[LINE_W-1:IDX_W]);

  assign mem.command = mem_bus_pkg::BUS_LOAD;
  assign mem.addr    = {16'h0, req_line, 3'b000};
  assign accepted    = mem.response != '0;

  assign fill_entry = tag_table[mem.tag];
  assign fill_idx   = IDX_W'(fill_entry.idx);

  always_comb begin
    next_head = head;
    next_tail = tail;
    if (!keep) begin
      next_head = idx; // restart the window at the missing line
      next_tail = idx;
    end else if (prefetch && accepted) begin
      next_tail = tail_next;
    end
  end

  always_comb begin
    next_lines = lines;
    // a response only lands if the line still belongs to the address it was fetched for
    if (mem.tag != '0 && lines[fill_idx].tag == fill_entry.tag) begin
      next_lines[fill_idx].valid = 1'b1;
      next_lines[fill_idx].data  = mem.data;
    end
    // claiming a line for a new address comes last and wins over a fill in the same cycle
    if (accepted && lines[req_idx].tag != req_tag) begin
      next_lines[req_idx].valid = 1'b0;
      next_lines[req_idx].tag   = req_tag;
    end
  end

  always_comb begin
    next_tag_table = tag_table;
    if (accepted) begin
      next_tag_table[mem.response].idx = 7'(req_idx);
      next_tag_table[mem.response].tag = req_tag;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      lines     <= '0;
      tag_table <= '0;
      head      <= '0;
      tail      <= '0;
    end else begin
      lines     <= next_lines;
      tag_table <= next_tag_table;
      head      <= next_head;
      tail      <= next_tail;
    end
  end

endmodule

`default_nettype wire

// ==== hw/imem_bus_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface imem_bus_if;

  mem_bus_pkg::bus_command_e command;
  logic [31:0]               addr;
  mem_bus_pkg::mem_tag_t     response; // same cycle as the request
  logic [63:0]               data;
  mem_bus_pkg::mem_tag_t     tag;      // qualifies data, zero when idle

  modport cache (
    output command,
    output addr,
    input  response,
    input  data,
    input  tag
  );

  modport memory (
    input  command,
    input  addr,
    output response,
    output data,
    output tag
  );

endinterface

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // conditional branch layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_view_t;

  // jal layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_view_t;

  typedef union packed {
    b_view_t     b;
    j_view_t     j;
    logic [31:0] raw;
  } instr_word_u;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        taken; // the sequencer left the straight-line path after this word
  } fetch_packet_t;

endpackage

`default_nettype wire

// ==== hw/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  // command on the instruction memory bus, the cache only ever loads
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_e;

  // transaction tag handed out by memory, zero means no transaction
  typedef logic [3:0] mem_tag_t;

  localparam int LINE_TAG_W = 6; // address bits 15:10 for the default 128 lines

  typedef struct packed {
    logic                  valid;
    logic [LINE_TAG_W-1:0] tag;
    logic [63:0]           data;
  } icache_line_t;

  // where a pending response lands and which address it was fetched for
  typedef struct packed {
    logic [6:0]            idx;
    logic [LINE_TAG_W-1:0] tag;
  } mem_tag_entry_t;

endpackage

`default_nettype wire
